/* vlog.f */
fetch_pkg.sv
apb_pkg.sv
fetch_pc_gen.sv
fetch_line_store.sv
fetch_fill_port.sv
fetch_stage.sv
fetch_top.sv
tb_fetch_checker.sv
tb_fetch.sv

/* Makefile */
# Verilator build and run of the fetch front end testbench
VERILATOR ?= verilator
TOP ?= tb_fetch
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_fetch.sv */
// ==================================================
// Table-driven testbench for the fetch front end
// Clock, LFSR data, APB tasks, reference model
// and watchdog
// ==================================================

`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*, apb_pkg::*; ();

	localparam int PERIOD = 8;
	localparam logic [15:0] RST_PC = 16'h0100;
	localparam int INDEX_BITS = 4;
	localparam int DEPTH = 1 << INDEX_BITS;
	// Longest row in clock cycles, used to size the watchdog
	localparam int ROW_CYCLES = 3;

	typedef enum logic [2:0] {
		DO_APBW, DO_APBR, DO_FETCH, DO_STALL, DO_REDIR, DO_FLUSH, DO_STOMP
	} op_e;
	// Where the expected line comes from after the row
	typedef enum logic [1:0] {SRC_HOLD, SRC_NOP, SRC_STORE, SRC_INJ} src_e;

	typedef struct packed {
		op_e op;
		logic [15:0] a;
		logic [31:0] b;
		fetch_addr_t slot0;
		src_e src;
		logic flush;
		logic slverr;
	} row_t;

	logic clk;
	logic rst;
	logic en_i;
	logic stall_i;
	logic redirect_i;
	logic [15:0] redirect_pc_i;
	logic flush_i;
	logic stomp_i;
	logic [2:0] kept_stream_i;
	apb_req_t apb_i;
	apb_rsp_t apb_o;
	fetch_out_t fetch_o;

	row_t table_q[$];
	logic [15:0] lfsr;
	int n_checks;
	int n_errors;

	// ==================================================
	// Reference model state
	// ==================================================

	// Shadow of the direct-mapped store
	logic m_valid [DEPTH];
	int m_tag [DEPTH];
	fetch_line_t m_line [DEPTH];
	// PC generator address and the address last registered by the stage
	fetch_addr_t m_addr;
	fetch_addr_t m_slot0;
	logic [31:0] m_lo;
	logic [31:0] m_hi;
	fetch_line_t exp_line;

	fetch_top #(.RST_PC(RST_PC), .INDEX_BITS(INDEX_BITS)) UUT (
		.clk(clk), .rst(rst), .en_i(en_i), .stall_i(stall_i),
		.redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
		.flush_i(flush_i), .stomp_i(stomp_i), .kept_stream_i(kept_stream_i),
		.apb_i(apb_i), .apb_o(apb_o), .fetch_o(fetch_o)
	);

	bind fetch_top tb_fetch_checker #(.RST_PC(RST_PC)) u_checker (
		.clk(clk), .rst(rst), .en_i(en_i), .stall_i(stall_i),
		.inject_i(fill_inject), .inj_line_i(fill_line), .apb_i(apb_i),
		.fetch_o(fetch_o)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Line index and tag of a byte address, offset bits dropped
	function automatic int line_index(logic [15:0] pc);
		return (int'(pc) / LINE_BYTES) % DEPTH;
	endfunction

	function automatic int line_tag(logic [15:0] pc);
		return int'(pc) / (LINE_BYTES * DEPTH);
	endfunction

	function automatic logic model_hit(logic [15:0] pc);
		return m_valid[line_index(pc)] && m_tag[line_index(pc)] == line_tag(pc);
	endfunction

	// Galois LFSR, taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per data bit
	task automatic rand_word(output logic [31:0] w);
		for (int n = 0; n < 32; n++) begin
			w[n] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic add_row(input op_e op, input logic [15:0] a, input logic [31:0] b,
		input fetch_addr_t slot0, input src_e src, input logic flush, input logic slverr);
		row_t r;
		r.op = op;
		r.a = a;
		r.b = b;
		r.slot0 = slot0;
		r.src = src;
		r.flush = flush;
		r.slverr = slverr;
		table_q.push_back(r);
	endtask

	task automatic check_value(input int row, input string what, input logic [63:0] got,
		input logic [63:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("CHECK FAILED at %0d ns: row %0d %s is %h, expected %h",
				$time, row, what, got, exp);
		end
	endtask

	// Setup and access cycle, then one more edge so the strobes land
	// The response is sampled in the middle of the access cycle
	task automatic apb_transfer(input logic write, input logic [7:0] paddr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr,
		output logic ready);
		apb_i.psel = 1'b1;
		apb_i.penable = 1'b0;
		apb_i.pwrite = write;
		apb_i.paddr = paddr;
		apb_i.pwdata = wdata;
		@(negedge clk);
		apb_i.penable = 1'b1;
		#(PERIOD / 4);
		rdata = apb_o.prdata;
		slverr = apb_o.pslverr;
		ready = apb_o.pready;
		@(negedge clk);
		apb_i = '0;
		@(negedge clk);
	endtask

	// ==================================================
	// Row execution and model update
	// ==================================================

	task automatic apply_row(input int i);
		row_t r;
		fetch_addr_t exp_a;
		logic [31:0] wdata;
		logic [31:0] rdata;
		logic [31:0] exp_rd;
		logic slverr;
		logic ready;
		logic hit;
		logic kill;
		int idx;
		r = table_q[i];
		wdata = r.b;
		case (r.op)
			DO_APBW, DO_APBR: begin
				// Line halves always carry fresh random data
				if (r.op == DO_APBW && (r.a[7:0] == REG_LO || r.a[7:0] == REG_HI))
					rand_word(wdata);
				apb_transfer(r.op == DO_APBW, r.a[7:0], wdata, rdata, slverr, ready);
				// No wait states, the access cycle always completes
				check_value(i, "pready", 64'(ready), 64'(1'b1));
				if (r.op == DO_APBW && !r.slverr) begin
					case (r.a[7:0])
						REG_LO: m_lo = wdata;
						REG_HI: m_hi = wdata;
						REG_WRITE: begin
							idx = line_index(wdata[15:0]);
							m_valid[idx] = 1'b1;
							m_tag[idx] = line_tag(wdata[15:0]);
							m_line[idx] = {m_hi, m_lo};
						end
						default: ;
					endcase
				end
				if (r.op == DO_APBR && !r.slverr) begin
					exp_rd = (r.a[7:0] == REG_LO) ? m_lo : (r.a[7:0] == REG_HI) ? m_hi : 32'd0;
					check_value(i, "read data", 64'(rdata), 64'(exp_rd));
				end
			end
			DO_STALL: begin
				// Stall, then enable low, with a flush request that must be ignored
				flush_i = 1'b1;
				@(negedge clk);
				en_i = 1'b0;
				stall_i = 1'b0;
				@(negedge clk);
				en_i = 1'b1;
				stall_i = 1'b1;
				flush_i = 1'b0;
				@(negedge clk);
				slverr = apb_o.pslverr;
			end
			default: begin
				hit = model_hit(m_addr.pc);
				kill = !hit || r.op == DO_FLUSH ||
					(r.op == DO_STOMP && m_addr.stream != r.a[2:0]);
				if ((r.src == SRC_STORE) == kill) begin
					n_errors++;
					$display("Table row %0d line source disagrees with the reference model", i);
				end
				stall_i = 1'b0;
				redirect_i = (r.op == DO_REDIR);
				redirect_pc_i = r.a;
				flush_i = (r.op == DO_FLUSH);
				stomp_i = (r.op == DO_STOMP);
				kept_stream_i = r.a[2:0];
				@(negedge clk);
				stall_i = 1'b1;
				redirect_i = 1'b0;
				flush_i = 1'b0;
				stomp_i = 1'b0;
				slverr = apb_o.pslverr;
				// The stage took the old address, the PC moves on
				m_slot0 = m_addr;
				if (r.op == DO_REDIR) begin
					m_addr.pc = r.a;
					m_addr.stream = m_addr.stream + 3'd1;
				end
				else if (hit) begin
					m_addr.pc = m_addr.pc + 16'(LINE_BYTES);
				end
			end
		endcase
		case (r.src)
			SRC_NOP: exp_line = NOP_LINE;
			SRC_STORE: exp_line = m_line[line_index(m_slot0.pc)];
			SRC_INJ: exp_line = {m_hi, m_lo};
			default: ;
		endcase
		if (r.slot0 != m_slot0) begin
			n_errors++;
			$display("Table row %0d slot 0 address %h differs from the model's %h",
				i, r.slot0, m_slot0);
		end
		for (int k = 0; k < SLOTS; k++) begin
			exp_a.stream = r.slot0.stream;
			exp_a.pc = r.slot0.pc + 16'(k * SLOT_BYTES);
			check_value(i, "slot address", 64'(fetch_o.slot_addr[k]), 64'(exp_a));
		end
		check_value(i, "line", 64'(fetch_o.line), 64'(exp_line));
		check_value(i, "flush flag", 64'(fetch_o.flush), 64'(r.flush));
		check_value(i, "pslverr", 64'(slverr), 64'(r.slverr));
	endtask

	// ==================================================
	// Main sequence
	// ==================================================

	initial begin : main
		int limit;
		rst = 1'b1;
		en_i = 1'b1;
		stall_i = 1'b1;
		redirect_i = 1'b0;
		redirect_pc_i = 16'h0000;
		flush_i = 1'b0;
		stomp_i = 1'b0;
		kept_stream_i = 3'd0;
		apb_i = '0;
		lfsr = 16'd60;
		n_checks = 0;
		n_errors = 0;
		foreach (m_valid[j])
			m_valid[j] = 1'b0;
		m_addr = '{stream: RST_STREAM, pc: RST_PC};
		m_slot0 = m_addr;
		m_lo = 32'd0;
		m_hi = 32'd0;
		exp_line = NOP_LINE;

		// Reset values, then fetches from an empty store
		add_row(DO_STALL, 16'h0000, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h1_0100, SRC_NOP, 1'b0, 1'b0);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h1_0100, SRC_NOP, 1'b0, 1'b0);
		// Fill the current and the next line, read the words back
		add_row(DO_APBW, 16'h0000, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h0004, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h0008, 32'h0100, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBR, 16'h0000, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBR, 16'h0004, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h0000, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h0004, 32'h0, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h0008, 32'h0108, 19'h1_0100, SRC_HOLD, 1'b0, 1'b0);
		// Sequential flow through both lines into a miss
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h1_0100, SRC_STORE, 1'b0, 1'b0);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h1_0108, SRC_STORE, 1'b0, 1'b0);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h1_0110, SRC_NOP, 1'b0, 1'b0);
		add_row(DO_STALL, 16'h0000, 32'h0, 19'h1_0110, SRC_HOLD, 1'b0, 1'b0);
		// Redirects open new streams, stomps and a flush kill lines
		add_row(DO_REDIR, 16'h0100, 32'h0, 19'h1_0110, SRC_NOP, 1'b0, 1'b0);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h2_0100, SRC_STORE, 1'b0, 1'b0);
		add_row(DO_STOMP, 16'h0001, 32'h0, 19'h2_0108, SRC_NOP, 1'b0, 1'b0);
		add_row(DO_REDIR, 16'h0108, 32'h0, 19'h2_0110, SRC_NOP, 1'b0, 1'b0);
		add_row(DO_STOMP, 16'h0003, 32'h0, 19'h3_0108, SRC_STORE, 1'b0, 1'b0);
		add_row(DO_REDIR, 16'h0100, 32'h0, 19'h3_0110, SRC_NOP, 1'b0, 1'b0);
		add_row(DO_FLUSH, 16'h0000, 32'h0, 19'h4_0100, SRC_NOP, 1'b1, 1'b0);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h4_0108, SRC_STORE, 1'b0, 1'b0);
		// Inject while stalled, register reads and a bad offset
		add_row(DO_APBW, 16'h0000, 32'h0, 19'h4_0108, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h0004, 32'h0, 19'h4_0108, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBW, 16'h000C, 32'h0, 19'h4_0108, SRC_INJ, 1'b0, 1'b0);
		add_row(DO_STALL, 16'h0000, 32'h0, 19'h4_0108, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBR, 16'h0000, 32'h0, 19'h4_0108, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBR, 16'h0004, 32'h0, 19'h4_0108, SRC_HOLD, 1'b0, 1'b0);
		add_row(DO_APBR, 16'h0010, 32'h0, 19'h4_0108, SRC_HOLD, 1'b0, 1'b1);
		add_row(DO_APBW, 16'h0010, 32'h5A5A, 19'h4_0108, SRC_HOLD, 1'b0, 1'b1);
		add_row(DO_FETCH, 16'h0000, 32'h0, 19'h4_0110, SRC_NOP, 1'b0, 1'b0);

		limit = (table_q.size() * ROW_CYCLES + 10) * PERIOD;
		fork
			begin
				#(limit);
				$display("Timeout: the run did not finish within %0d ns", limit);
				$display("CHECKS FAILED");
				$finish;
			end
		join_none

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (table_q[i])
			apply_row(i);

		$display("Checks run: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tb_fetch_checker.sv */
// ==================================================
// Bound assertions for the fetch front end
// Reset values, hold under stall, APB inject timing
// ==================================================

`timescale 1ns/1ps

module tb_fetch_checker import fetch_pkg::*, apb_pkg::*; #(
	parameter logic [15:0] RST_PC = 16'h0100
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic stall_i,
	// Inject strobe and line from the fill port to the stage
	input logic inject_i,
	input fetch_line_t inj_line_i,
	input apb_req_t apb_i,
	input fetch_out_t fetch_o
);

	// Stage keeps every register on this edge
	logic stage_held;
	// Access cycle of an APB write to the inject register
	logic inject_wr;

	assign stage_held = !(en_i && !stall_i) && !inject_i;
	assign inject_wr = apb_i.psel && apb_i.penable && apb_i.pwrite
		&& apb_i.paddr == REG_INJECT;

	// Reset leaves a no-operation line at the reset address with flush low
	a_reset_values: assert property (@(posedge clk) rst |=> (fetch_o.line == NOP_LINE)
		&& !fetch_o.flush && fetch_o.slot_addr[0].pc == RST_PC
		&& fetch_o.slot_addr[0].stream == RST_STREAM)
		else $error("fetch output does not hold its reset value after reset");

	// A held stage must not change its output bundle
	a_stall_hold: assert property (@(posedge clk) disable iff (rst)
		stage_held |=> $stable(fetch_o))
		else $error("fetch output changed while the stage was held");

	// An inject write lands in the line register on the edge after its access cycle
	// This holds whether or not the stage is enabled
	a_inject_line: assert property (@(posedge clk) disable iff (rst)
		$past(inject_wr, 2) |-> (fetch_o.line == $past(inj_line_i)))
		else $error("injected line did not reach the fetch output");

endmodule

/* fetch_top.sv */
// ==================================================
// Instruction fetch front end top level
// PC generator, line store, APB fill port, stage
// ==================================================

`timescale 1ns/1ps

module fetch_top import fetch_pkg::*, apb_pkg::*; #(
	parameter logic [15:0] RST_PC = 16'h0100,
	parameter int INDEX_BITS = 4
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic stall_i,
	input logic redirect_i,
	input logic [15:0] redirect_pc_i,
	input logic flush_i,
	input logic stomp_i,
	input logic [2:0] kept_stream_i,
	// Fill and inject path
	input apb_req_t apb_i,
	output apb_rsp_t apb_o,
	output fetch_out_t fetch_o
);

	// Enable shared by the PC generator and the stage
	logic advance;
	fetch_addr_t fetch_addr;
	fetch_line_t store_line;
	logic store_hit;

	logic fill_wr;
	logic [15:0] fill_wr_addr;
	logic fill_inject;
	fetch_line_t fill_line;

	assign advance = en_i & ~stall_i;

	// ==================================================
	// Instances
	// ==================================================

	fetch_pc_gen #(.RST_PC(RST_PC)) u_pc_gen (
		.clk(clk), .rst(rst),
		.advance_i(advance), .redirect_i(redirect_i), .hit_i(store_hit),
		.redirect_pc_i(redirect_pc_i), .addr_o(fetch_addr)
	);

	fetch_line_store #(.INDEX_BITS(INDEX_BITS)) u_store (
		.clk(clk), .rst(rst), .addr_i(fetch_addr),
		.wr_i(fill_wr), .wr_addr_i(fill_wr_addr), .wr_line_i(fill_line),
		.line_o(store_line), .hit_o(store_hit)
	);

	fetch_fill_port u_fill (
		.clk(clk), .rst(rst), .apb_i(apb_i), .apb_o(apb_o),
		.wr_o(fill_wr), .wr_addr_o(fill_wr_addr),
		.inject_o(fill_inject), .line_o(fill_line)
	);

	fetch_stage #(.RST_PC(RST_PC)) u_stage (
		.clk(clk), .rst(rst), .en_i(en_i), .stall_i(stall_i),
		.addr_i(fetch_addr), .line_i(store_line), .hit_i(store_hit),
		.flush_i(flush_i), .stomp_i(stomp_i), .kept_stream_i(kept_stream_i),
		.inject_i(fill_inject), .inj_line_i(fill_line), .fetch_o(fetch_o)
	);

endmodule

/* fetch_stage.sv */
// ==================================================
// Fetch pipeline register
// Slot addresses, fetched line and flush flag
// with no-operation substitution and line inject
// ==================================================

`timescale 1ns/1ps

module fetch_stage import fetch_pkg::*; #(
	parameter logic [15:0] RST_PC = 16'h0100
) (
	input logic clk,
	input logic rst,
	input logic en_i,
	input logic stall_i,
	// Fetch address and the lookup result for it
	input fetch_addr_t addr_i,
	input fetch_line_t line_i,
	input logic hit_i,
	input logic flush_i,
	// Stomp discards every stream except the kept one
	input logic stomp_i,
	input logic [2:0] kept_stream_i,
	// Line pushed in from the fill port
	input logic inject_i,
	input fetch_line_t inj_line_i,
	output fetch_out_t fetch_o
);

	// Stage moves only when enabled and not stalled
	logic stage_en;
	// Looked up line must not enter the pipeline
	logic kill_line;

	slot_addr_vec_t slot_d;
	slot_addr_vec_t slot_q;
	fetch_line_t line_q;
	logic flush_q;

	// Spread one fetch address over all slots of a line
	// Every slot keeps the stream tag of the base address
	function automatic slot_addr_vec_t slot_addrs(fetch_addr_t base);
		slot_addr_vec_t v;
		for (int k = 0; k < SLOTS; k++) begin
			v[k].stream = base.stream;
			v[k].pc = base.pc + pc_t'(k * SLOT_BYTES);
		end
		return v;
	endfunction

	assign stage_en = en_i & ~stall_i;

	// ==================================================
	// Slot addresses and flush flag
	// ==================================================

	assign slot_d = slot_addrs(addr_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_q <= slot_addrs('{stream: RST_STREAM, pc: RST_PC});
			flush_q <= 1'b0;
		end
		else if (stage_en) begin
			slot_q <= slot_d;
			flush_q <= flush_i;
		end
	end

	// ==================================================
	// Line register
	// ==================================================

	// Miss, flush and a stomp on a foreign stream all kill the line
	assign kill_line = ~hit_i | flush_i |
		(stomp_i & (addr_i.stream != kept_stream_i));

	// Inject updates the line even while the stage holds
	always_ff @(posedge clk) begin
		if (rst) begin
			line_q <= NOP_LINE;
		end
		else if (inject_i) begin
			line_q <= inj_line_i;
		end
		else if (stage_en) begin
			if (kill_line)
				line_q <= NOP_LINE;
			else
				line_q <= line_i;
		end
	end

	// Output bundle is read straight from the registers
	always_comb begin
		fetch_o.slot_addr = slot_q;
		fetch_o.line = line_q;
		fetch_o.flush = flush_q;
	end

endmodule

/* fetch_fill_port.sv */
// ==================================================
// APB slave for line fill and line injection
// Assembles a line from two words, then issues
// a store write or an inject strobe
// ==================================================

`timescale 1ns/1ps

module fetch_fill_port import fetch_pkg::*, apb_pkg::*; (
	input logic clk,
	input logic rst,
	input apb_req_t apb_i,
	output apb_rsp_t apb_o,
	// Store write strobe and line address
	output logic wr_o,
	output logic [15:0] wr_addr_o,
	// Fetch stage inject strobe
	output logic inject_o,
	// Assembled line, shared by store and stage
	output fetch_line_t line_o
);

	// Access cycle of a transfer, no wait states exist
	logic access;
	logic wr_access;
	// Offset is one of the four mapped registers
	logic known_ofs;

	// Line halves, payload only
	logic [31:0] lo_q;
	logic [31:0] hi_q;
	logic [15:0] wr_addr_q;
	// One cycle strobes issued after the access cycle
	logic wr_q;
	logic inject_q;

	assign access = apb_i.psel & apb_i.penable;
	assign wr_access = access & apb_i.pwrite;

	// ==================================================
	// Read data and response
	// ==================================================

	// Reads of the two strobe registers return zero
	always_comb begin
		known_ofs = 1'b1;
		apb_o.prdata = 32'd0;
		case (apb_i.paddr)
			REG_LO: apb_o.prdata = lo_q;
			REG_HI: apb_o.prdata = hi_q;
			REG_WRITE, REG_INJECT: apb_o.prdata = 32'd0;
			default: known_ofs = 1'b0;
		endcase
		apb_o.pready = 1'b1;
		// Error only in the access cycle of an unmapped offset
		apb_o.pslverr = access & ~known_ofs;
	end

	// ==================================================
	// Register writes
	// ==================================================

	always_ff @(posedge clk) begin
		if (wr_access && apb_i.paddr == REG_LO)
			lo_q <= apb_i.pwdata;
		if (wr_access && apb_i.paddr == REG_HI)
			hi_q <= apb_i.pwdata;
		if (wr_access && apb_i.paddr == REG_WRITE)
			wr_addr_q <= apb_i.pwdata[15:0];
	end

	// Strobes last a single cycle since transfers take two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_q <= 1'b0;
			inject_q <= 1'b0;
		end
		else begin
			wr_q <= wr_access && (apb_i.paddr == REG_WRITE);
			inject_q <= wr_access && (apb_i.paddr == REG_INJECT);
		end
	end

	assign wr_o = wr_q;
	assign wr_addr_o = wr_addr_q;
	assign inject_o = inject_q;
	// Low word carries slots 0 and 1
	assign line_o = fetch_line_t'({hi_q, lo_q});

endmodule

/* fetch_line_store.sv */
// ==================================================
// Direct-mapped instruction line store
// Combinational lookup with tag compare
// Line write from the APB fill port
// ==================================================

`timescale 1ns/1ps

module fetch_line_store import fetch_pkg::*; #(
	parameter int INDEX_BITS = 4
) (
	input logic clk,
	input logic rst,
	// Current fetch address
	input fetch_addr_t addr_i,
	// Write strobe, line address and line from the fill port
	input logic wr_i,
	input logic [15:0] wr_addr_i,
	input fetch_line_t wr_line_i,
	output fetch_line_t line_o,
	output logic hit_o
);

	// Number of lines held
	localparam int DEPTH = 1 << INDEX_BITS;
	// Address bits left above the index form the tag
	localparam int TAG_BITS = ADDR_BITS - LINE_OFS_BITS - INDEX_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// Line data and tag arrays
	fetch_line_t line_mem [DEPTH];
	tag_t tag_mem [DEPTH];
	// One valid bit per entry, the only state cleared by reset
	logic [DEPTH-1:0] valid_q;

	index_t rd_idx;
	tag_t rd_tag;
	index_t wr_idx;
	tag_t wr_tag;

	// ==================================================
	// Address split
	// ==================================================

	// The byte offset inside a line is ignored for both ports
	// The stream tag plays no part in the lookup
	assign rd_idx = addr_i.pc[LINE_OFS_BITS +: INDEX_BITS];
	assign rd_tag = addr_i.pc[ADDR_BITS-1 -: TAG_BITS];
	assign wr_idx = wr_addr_i[LINE_OFS_BITS +: INDEX_BITS];
	assign wr_tag = wr_addr_i[ADDR_BITS-1 -: TAG_BITS];

	// ==================================================
	// Lookup
	// ==================================================

	// Same cycle result, a hit needs a valid entry with a matching tag
	always_comb begin
		line_o = line_mem[rd_idx];
		hit_o = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	end

	// ==================================================
	// Write
	// ==================================================

	// Data and tag land on the strobe edge
	// A lookup sees them on the following cycle
	always_ff @(posedge clk) begin
		if (wr_i) begin
			line_mem[wr_idx] <= wr_line_i;
			tag_mem[wr_idx] <= wr_tag;
		end
	end

	// Entry turns valid with its first write and stays valid
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end
		else if (wr_i) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

endmodule

/* fetch_pc_gen.sv */
// ==================================================
// Fetch program counter generator
// Holds the fetch address and its stream tag
// ==================================================

`timescale 1ns/1ps

module fetch_pc_gen import fetch_pkg::*; #(
	parameter logic [15:0] RST_PC = 16'h0100
) (
	input logic clk,
	input logic rst,
	// Stage enable formed by the top level
	input logic advance_i,
	input logic redirect_i,
	// Lookup result for the current address
	input logic hit_i,
	input logic [15:0] redirect_pc_i,
	output fetch_addr_t addr_o
);

	fetch_addr_t addr_q;
	fetch_addr_t addr_d;

	// ==================================================
	// Next address selection
	// ==================================================

	// Redirect wins over sequential flow and opens a new stream
	// The stream tag wraps through all of its values
	// A miss keeps the address until the line is filled
	always_comb begin
		addr_d = addr_q;
		if (redirect_i) begin
			addr_d.pc = redirect_pc_i;
			addr_d.stream = addr_q.stream + stream_t'(1);
		end
		else if (hit_i) begin
			// Step to the following line, same stream
			addr_d.pc = addr_q.pc + pc_t'(LINE_BYTES);
		end
	end

	// ==================================================
	// Address register
	// ==================================================

	// Nothing moves while the stage is stalled or disabled
	always_ff @(posedge clk) begin
		if (rst) begin
			addr_q.stream <= RST_STREAM;
			addr_q.pc <= RST_PC;
		end
		else if (advance_i) begin
			addr_q <= addr_d;
		end
	end

	// The address feeds the store lookup and the stage directly
	assign addr_o = addr_q;

endmodule

/* apb_pkg.sv */
// ==================================================
// APB request and response bundles
// Register map of the line fill port
// ==================================================

package apb_pkg;

	// Master to slave side of the bus
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [7:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	// Slave to master side of the bus
	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// Low and high words of the line being assembled
	localparam logic [7:0] REG_LO = 8'h00;
	localparam logic [7:0] REG_HI = 8'h04;
	// Store the assembled line, pwdata carries the line address
	localparam logic [7:0] REG_WRITE = 8'h08;
	// Push the assembled line straight into the fetch stage
	localparam logic [7:0] REG_INJECT = 8'h0C;

endpackage

/* fetch_pkg.sv */
// ==================================================
// Fetch front end shared types and constants
// Fetch address with stream tag, instruction slot,
// fetch line and registered fetch output bundle
// ==================================================

package fetch_pkg;

	// ==================================================
	// Sizes
	// ==================================================

	// Byte address width of the fetch program counter
	localparam int ADDR_BITS = 16;
	// Stream tag width, a redirect moves to the next tag
	localparam int STREAM_BITS = 3;
	// Instruction parcels held in one fetch line
	localparam int SLOTS = 4;
	// Address step between consecutive slots of a line
	localparam int SLOT_BYTES = 2;
	// Address step between consecutive lines
	localparam int LINE_BYTES = 8;
	// Byte offset bits inside a line, below the store index
	localparam int LINE_OFS_BITS = $clog2(LINE_BYTES);

	typedef logic [ADDR_BITS-1:0] pc_t;
	typedef logic [STREAM_BITS-1:0] stream_t;

	// Fetch address, the stream tag sits above the byte address
	typedef struct packed {
		stream_t stream;
		pc_t pc;
	} fetch_addr_t;

	// One 16 bit instruction parcel
	typedef logic [15:0] slot_t;

	// Slot 0 occupies the low bits of the line
	typedef slot_t [SLOTS-1:0] fetch_line_t;

	// One fetch address per slot of the line
	typedef fetch_addr_t [SLOTS-1:0] slot_addr_vec_t;

	// Registered output of the fetch stage
	typedef struct packed {
		slot_addr_vec_t slot_addr;
		fetch_line_t line;
		logic flush;
	} fetch_out_t;

	// ==================================================
	// Constants
	// ==================================================

	localparam slot_t OP_NOP = 16'hE000;
	localparam fetch_line_t NOP_LINE = {SLOTS{OP_NOP}};
	// Stream tag held right after reset
	localparam stream_t RST_STREAM = 3'd1;

endpackage
